/* src/rvPkg.sv */
package rvPkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      regIdx_t;
    typedef logic [XLEN-3:0] memAddr_t;  // word address, byte offset dropped

    localparam word_t RESET_PC = '0;

    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // aluMode from the main decoder
    localparam logic [1:0] MODE_ADD = 2'b00;  // address and link
    localparam logic [1:0] MODE_REG = 2'b10;
    localparam logic [1:0] MODE_IMM = 2'b11;

    typedef enum logic [3:0] {
        ALU_AND = 4'd0,
        ALU_OR  = 4'd1,
        ALU_ADD = 4'd2,
        ALU_SLL = 4'd3,
        ALU_SRL = 4'd4,
        ALU_SRA = 4'd5,
        ALU_SUB = 4'd6,
        ALU_SLT = 4'd7,
        ALU_XOR = 4'd8
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwdSel_t;

    // memory ports carry words with the bytes reversed
    function automatic word_t byteSwap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
                                     input word_t memVal, input word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

endpackage

/* src/hazardCtrl.sv */
`timescale 1ns/1ps

module hazardCtrl (
    input  rvPkg::word_t   instr,
    input  rvPkg::regIdx_t exRd,
    input  logic           exRegWrite,
    input  logic           exMemRead,
    input  rvPkg::regIdx_t memRd,
    input  logic           memRegWrite,
    input  logic           memMemRead,
    input  rvPkg::regIdx_t wbRd,
    input  logic           wbRegWrite,
    input  rvPkg::regIdx_t exRs1,
    input  rvPkg::regIdx_t exRs2,
    output logic           regWrite,
    output logic           memRead,
    output logic           memWrite,
    output logic           memToReg,
    output logic           aluSrc,
    output logic [1:0]     aluMode,
    output logic           isBranch,
    output logic           isJal,
    output logic           stall,
    output rvPkg::fwdSel_t fwdIdA,
    output rvPkg::fwdSel_t fwdIdB,
    output rvPkg::fwdSel_t fwdExA,
    output rvPkg::fwdSel_t fwdExB
);
    import rvPkg::*;

    regIdx_t    rs1;
    regIdx_t    rs2;
    logic [6:0] decBits;  // regWrite memRead memWrite memToReg aluSrc isBranch isJal
    logic [1:0] decMode;
    logic       exHit;
    logic       memHit;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // main decoder, full opcode match so low bits other than 11 give nothing
    always_comb begin
        decBits = '0;
        decMode = MODE_ADD;
        case (instr[6:0])
            OP_RTYPE: begin
                decBits = 7'b1000000;
                decMode = MODE_REG;
            end
            OP_ITYPE: begin
                decBits = 7'b1000100;
                decMode = MODE_IMM;
            end
            OP_LOAD:   decBits = 7'b1101100;
            OP_STORE:  decBits = 7'b0010100;
            OP_BRANCH: decBits = 7'b0000010;
            OP_JAL:    decBits = 7'b1000001;  // writes the link
            default:   decBits = '0;
        endcase
    end

    assign exHit  = exRd != '0 && (exRd == rs1 || exRd == rs2);
    assign memHit = memRd != '0 && (memRd == rs1 || memRd == rs2);

    // load-use, or a branch waiting for a value it can forward next cycle
    assign stall = (exMemRead && exHit)
                || (decBits[1] && ((exRegWrite && exHit) || (memMemRead && memHit)));

    always_comb begin
        {regWrite, memRead, memWrite, memToReg, aluSrc, isBranch, isJal} = '0;
        aluMode = MODE_ADD;
        if (!stall) begin
            {regWrite, memRead, memWrite, memToReg, aluSrc, isBranch, isJal} = decBits;
            aluMode = decMode;
        end
    end

    function automatic fwdSel_t pickSource(input regIdx_t rs);
        if (rs == '0)
            return FWD_REG;
        if (memRegWrite && memRd == rs)
            return FWD_MEM;  // youngest value wins
        if (wbRegWrite && wbRd == rs)
            return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        fwdIdA = pickSource(rs1);
        fwdIdB = pickSource(rs2);
        fwdExA = pickSource(exRs1);
        fwdExB = pickSource(exRs2);
    end

endmodule

/* src/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            branchTaken,
    input  rvPkg::word_t    branchTarget,
    input  rvPkg::word_t    icacheRdata,
    output rvPkg::memAddr_t icacheAddr,
    output rvPkg::word_t    ifPc,
    output rvPkg::word_t    ifPcPlus4,
    output rvPkg::word_t    ifInstr
);
    import rvPkg::*;

    word_t pc;
    word_t pcPlus4;

    assign pcPlus4    = pc + 32'd4;
    assign icacheAddr = pc[XLEN-1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= branchTaken ? branchTarget : pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ifInstr <= '0;
        end else if (!stall) begin
            ifInstr <= branchTaken ? '0 : byteSwap(icacheRdata);  // flush on redirect
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifPc      <= pc;
            ifPcPlus4 <= pcPlus4;
        end
    end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  logic           rst_n,
    input  rvPkg::regIdx_t rs1,
    input  rvPkg::regIdx_t rs2,
    input  logic           wrEn,
    input  rvPkg::regIdx_t rd,
    input  rvPkg::word_t   wrData,
    output rvPkg::word_t   rdData1,
    output rvPkg::word_t   rdData2
);
    import rvPkg::*;

    word_t regs [NUM_REGS];
    logic  wrLive;

    assign wrLive = wrEn && rd != '0;

    // x0 reads zero, same-cycle write is bypassed
    assign rdData1 = (rs1 == '0) ? '0 : (wrLive && rd == rs1) ? wrData : regs[rs1];
    assign rdData2 = (rs2 == '0) ? '0 : (wrLive && rd == rs2) ? wrData : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[rd] <= wrData;
        end
    end

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  rvPkg::word_t   instr,
    input  rvPkg::word_t   pc,
    input  rvPkg::word_t   pcPlus4,
    input  rvPkg::word_t   rdData1,
    input  rvPkg::word_t   rdData2,
    input  logic           regWrite,
    input  logic           memRead,
    input  logic           memWrite,
    input  logic           memToReg,
    input  logic           aluSrc,
    input  logic [1:0]     aluMode,
    input  logic           isBranch,
    input  logic           isJal,
    input  rvPkg::fwdSel_t fwdIdA,
    input  rvPkg::fwdSel_t fwdIdB,
    input  rvPkg::word_t   memValue,
    input  rvPkg::word_t   wbValue,
    output logic           branchTaken,
    output rvPkg::word_t   branchTarget,
    output rvPkg::regIdx_t exRs1,
    output rvPkg::regIdx_t exRs2,
    output rvPkg::regIdx_t exRd,
    output rvPkg::word_t   exOpA,
    output rvPkg::word_t   exOpB,
    output rvPkg::word_t   exImm,
    output rvPkg::word_t   exPcPlus4,
    output logic [3:0]     exFunct,
    output logic           exRegWrite,
    output logic           exMemRead,
    output logic           exMemWrite,
    output logic           exMemToReg,
    output logic           exAluSrc,
    output logic [1:0]     exAluMode,
    output logic           exIsJal
);
    import rvPkg::*;

    word_t imm;
    word_t opA;
    word_t opB;
    logic  opEqual;

    always_comb begin
        case (instr[6:0])
            OP_ITYPE, OP_LOAD: imm = {{20{instr[31]}}, instr[31:20]};
            OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:   imm = '0;
        endcase
    end

    assign opA     = fwdMux(fwdIdA, rdData1, memValue, wbValue);
    assign opB     = fwdMux(fwdIdB, rdData2, memValue, wbValue);
    assign opEqual = opA == opB;

    // funct3 bit 0 separates bne from beq
    assign branchTaken  = isJal || (isBranch && (instr[12] ? !opEqual : opEqual));
    assign branchTarget = pc + imm;

    always_ff @(posedge clk) begin
        if (!rst_n || stall) begin  // bubble
            {exRegWrite, exMemRead, exMemWrite, exMemToReg, exAluSrc, exIsJal} <= '0;
            exAluMode <= MODE_ADD;
        end else begin
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exMemToReg <= memToReg;
            exAluSrc   <= aluSrc;
            exAluMode  <= aluMode;
            exIsJal    <= isJal;
        end
    end

    always_ff @(posedge clk) begin
        exRs1     <= instr[19:15];
        exRs2     <= instr[24:20];
        exRd      <= instr[11:7];
        exOpA     <= opA;
        exOpB     <= opB;
        exImm     <= imm;
        exPcPlus4 <= pcPlus4;
        exFunct   <= {instr[30], instr[14:12]};
    end

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic           clk,
    input  logic           rst_n,
    input  rvPkg::regIdx_t exRd,
    input  rvPkg::word_t   exOpA,
    input  rvPkg::word_t   exOpB,
    input  rvPkg::word_t   exImm,
    input  rvPkg::word_t   exPcPlus4,
    input  logic [3:0]     exFunct,
    input  logic           exRegWrite,
    input  logic           exMemRead,
    input  logic           exMemWrite,
    input  logic           exMemToReg,
    input  logic           exAluSrc,
    input  logic [1:0]     exAluMode,
    input  logic           exIsJal,
    input  rvPkg::fwdSel_t fwdExA,
    input  rvPkg::fwdSel_t fwdExB,
    input  rvPkg::word_t   wbValue,
    output rvPkg::word_t   memValue,
    output rvPkg::word_t   memAluOut,
    output rvPkg::word_t   memStoreData,
    output rvPkg::regIdx_t memRd,
    output logic           memRegWrite,
    output logic           memMemRead,
    output logic           memMemWrite,
    output logic           memMemToReg,
    output logic           memIsJal,
    output rvPkg::word_t   memPcPlus4
);
    import rvPkg::*;

    word_t  srcA;
    word_t  srcB;
    word_t  aluB;
    word_t  aluOut;
    aluOp_t aluOp;

    assign memValue = memIsJal ? memPcPlus4 : memAluOut;  // link for jal
    assign srcA     = fwdMux(fwdExA, exOpA, memValue, wbValue);
    assign srcB     = fwdMux(fwdExB, exOpB, memValue, wbValue);
    assign aluB     = exAluSrc ? exImm : srcB;

    always_comb begin
        aluOp = ALU_ADD;
        if (exAluMode != MODE_ADD) begin
            case (exFunct[2:0])
                3'b000:  aluOp = (exAluMode == MODE_REG && exFunct[3]) ? ALU_SUB : ALU_ADD;
                3'b001:  aluOp = ALU_SLL;
                3'b010:  aluOp = ALU_SLT;
                3'b100:  aluOp = ALU_XOR;
                3'b101:  aluOp = exFunct[3] ? ALU_SRA : ALU_SRL;
                3'b110:  aluOp = ALU_OR;
                3'b111:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            ALU_AND: aluOut = srcA & aluB;
            ALU_OR:  aluOut = srcA | aluB;
            ALU_ADD: aluOut = srcA + aluB;
            ALU_SUB: aluOut = srcA - aluB;
            ALU_SLL: aluOut = srcA << aluB[4:0];
            ALU_SRL: aluOut = srcA >> aluB[4:0];
            ALU_SRA: aluOut = $signed(srcA) >>> aluB[4:0];
            ALU_SLT: aluOut = {31'b0, $signed(srcA) < $signed(aluB)};
            ALU_XOR: aluOut = srcA ^ aluB;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {memRegWrite, memMemRead, memMemWrite, memMemToReg, memIsJal} <= '0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memMemToReg <= exMemToReg;
            memIsJal    <= exIsJal;
        end
    end

    always_ff @(posedge clk) begin
        memAluOut    <= aluOut;
        memStoreData <= srcB;  // forwarded rs2 for sw
        memRd        <= exRd;
        memPcPlus4   <= exPcPlus4;
    end

endmodule

/* src/memWbStage.sv */
`timescale 1ns/1ps

module memWbStage (
    input  logic            clk,
    input  logic            rst_n,
    input  rvPkg::word_t    memAluOut,
    input  rvPkg::word_t    memStoreData,
    input  rvPkg::regIdx_t  memRd,
    input  logic            memRegWrite,
    input  logic            memMemRead,
    input  logic            memMemWrite,
    input  logic            memMemToReg,
    input  logic            memIsJal,
    input  rvPkg::word_t    memPcPlus4,
    input  rvPkg::word_t    dcacheRdata,
    output logic            dcacheRen,
    output logic            dcacheWen,
    output rvPkg::memAddr_t dcacheAddr,
    output rvPkg::word_t    dcacheWdata,
    output rvPkg::word_t    wbValue,
    output rvPkg::regIdx_t  wbRd,
    output logic            wbRegWrite
);
    import rvPkg::*;

    word_t wbAlu;
    word_t wbLoad;
    word_t wbLink;
    logic  wbMemToReg;
    logic  wbIsJal;

    assign dcacheRen   = memMemRead;
    assign dcacheWen   = memMemWrite;
    assign dcacheAddr  = memAluOut[XLEN-1:2];
    assign dcacheWdata = byteSwap(memStoreData);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {wbRegWrite, wbMemToReg, wbIsJal} <= '0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbMemToReg <= memMemToReg;
            wbIsJal    <= memIsJal;
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= memRd;
        wbAlu  <= memAluOut;
        wbLoad <= byteSwap(dcacheRdata);
        wbLink <= memPcPlus4;
    end

    assign wbValue = wbIsJal ? wbLink : (wbMemToReg ? wbLoad : wbAlu);

endmodule

/* src/rvPipeline.sv */
`timescale 1ns/1ps

module rvPipeline (
    input  logic            clk,
    input  logic            rst_n,
    output rvPkg::memAddr_t icacheAddr,
    input  rvPkg::word_t    icacheRdata,
    output logic            dcacheRen,
    output logic            dcacheWen,
    output rvPkg::memAddr_t dcacheAddr,
    output rvPkg::word_t    dcacheWdata,
    input  rvPkg::word_t    dcacheRdata
);
    import rvPkg::*;

    word_t      ifPc, ifPcPlus4, ifInstr, branchTarget, rdData1, rdData2;
    word_t      exOpA, exOpB, exImm, exPcPlus4;
    word_t      memValue, memAluOut, memStoreData, memPcPlus4, wbValue;
    regIdx_t    exRs1, exRs2, exRd, memRd, wbRd;
    logic       stall, branchTaken;
    logic       regWrite, memRead, memWrite, memToReg, aluSrc, isBranch, isJal;
    logic [1:0] aluMode, exAluMode;
    logic [3:0] exFunct;
    logic       exRegWrite, exMemRead, exMemWrite, exMemToReg, exAluSrc, exIsJal;
    logic       memRegWrite, memMemRead, memMemWrite, memMemToReg, memIsJal;
    logic       wbRegWrite;
    fwdSel_t    fwdIdA, fwdIdB, fwdExA, fwdExB;

    hazardCtrl hazardCtrl_i (
        .instr(ifInstr), .exRd, .exRegWrite, .exMemRead,
        .memRd, .memRegWrite, .memMemRead, .wbRd, .wbRegWrite, .exRs1, .exRs2,
        .regWrite, .memRead, .memWrite, .memToReg, .aluSrc, .aluMode, .isBranch, .isJal,
        .stall, .fwdIdA, .fwdIdB, .fwdExA, .fwdExB
    );

    fetchUnit fetchUnit_i (
        .clk, .rst_n, .stall, .branchTaken, .branchTarget, .icacheRdata,
        .icacheAddr, .ifPc, .ifPcPlus4, .ifInstr
    );

    regFile regFile_i (
        .clk, .rst_n, .rs1(ifInstr[19:15]), .rs2(ifInstr[24:20]),
        .wrEn(wbRegWrite), .rd(wbRd), .wrData(wbValue), .rdData1, .rdData2
    );

    decodeStage decodeStage_i (
        .clk, .rst_n, .stall, .instr(ifInstr), .pc(ifPc), .pcPlus4(ifPcPlus4),
        .rdData1, .rdData2, .regWrite, .memRead, .memWrite, .memToReg, .aluSrc,
        .aluMode, .isBranch, .isJal, .fwdIdA, .fwdIdB, .memValue, .wbValue,
        .branchTaken, .branchTarget, .exRs1, .exRs2, .exRd, .exOpA, .exOpB, .exImm,
        .exPcPlus4, .exFunct, .exRegWrite, .exMemRead, .exMemWrite, .exMemToReg,
        .exAluSrc, .exAluMode, .exIsJal
    );

    executeStage executeStage_i (
        .clk, .rst_n, .exRd, .exOpA, .exOpB, .exImm, .exPcPlus4, .exFunct,
        .exRegWrite, .exMemRead, .exMemWrite, .exMemToReg, .exAluSrc, .exAluMode,
        .exIsJal, .fwdExA, .fwdExB, .wbValue,
        .memValue, .memAluOut, .memStoreData, .memRd, .memRegWrite, .memMemRead,
        .memMemWrite, .memMemToReg, .memIsJal, .memPcPlus4
    );

    memWbStage memWbStage_i (
        .clk, .rst_n, .memAluOut, .memStoreData, .memRd, .memRegWrite, .memMemRead,
        .memMemWrite, .memMemToReg, .memIsJal, .memPcPlus4, .dcacheRdata,
        .dcacheRen, .dcacheWen, .dcacheAddr, .dcacheWdata, .wbValue, .wbRd, .wbRegWrite
    );

endmodule

/* tests/memModel.sv */
`timescale 1ns/1ps

module memModel (
    input  logic            clk,
    input  rvPkg::memAddr_t icacheAddr,
    output rvPkg::word_t    icacheRdata,
    input  logic            dcacheRen,
    input  logic            dcacheWen,
    input  rvPkg::memAddr_t dcacheAddr,
    input  rvPkg::word_t    dcacheWdata,
    output rvPkg::word_t    dcacheRdata
);
    import rvPkg::*;

    localparam int ROM_WORDS = 64;
    localparam int RAM_WORDS = 256;
    localparam int LOG_DEPTH = 64;

    word_t    rom [ROM_WORDS];
    word_t    ram [RAM_WORDS];
    memAddr_t logAddr [LOG_DEPTH];
    word_t    logData [LOG_DEPTH];
    int       logCount;

    function automatic word_t reverseBytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign icacheRdata = (icacheAddr < ROM_WORDS) ? rom[icacheAddr[5:0]] : '0;  // zero is a nop
    assign dcacheRdata = dcacheRen ? ram[dcacheAddr[7:0]] : '0;

    task automatic clearMemory();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = 32'h9e3779b9 * (i + 1);  // differs at every address
        end
        logCount = 0;
    endtask

    task automatic putInstr(input int idx, input word_t w);
        rom[idx] = reverseBytes(w);
    endtask

    // stores are logged with the bytes back in order
    always @(posedge clk) begin
        if (dcacheWen === 1'b1) begin
            ram[dcacheAddr[7:0]] = dcacheWdata;
            if (logCount < LOG_DEPTH) begin
                logAddr[logCount] = dcacheAddr;
                logData[logCount] = reverseBytes(dcacheWdata);
            end
            logCount++;
        end
    end

endmodule

/* tests/tbRvPipeline.sv */
`timescale 1ns/1ps

module tbRvPipeline;
    import rvPkg::*;

    localparam int MAX_WAIT = 300;
    // funct3 of the chained ALU ops, op 0 in the low bits, ops 9 and up are immediates
    localparam logic [50:0] CHAIN_F3 = {3'd5, 3'd5, 3'd1, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0,
                                        3'd2, 3'd5, 3'd5, 3'd1, 3'd4, 3'd6, 3'd7, 3'd0, 3'd0};
    localparam logic [16:0] CHAIN_ALT = 17'b10000000010000010;  // sub, sra, srai

    logic     clk;
    logic     rst_n;
    memAddr_t icacheAddr;
    word_t    icacheRdata;
    logic     dcacheRen;
    logic     dcacheWen;
    memAddr_t dcacheAddr;
    word_t    dcacheWdata;
    word_t    dcacheRdata;
    word_t    prog [64];
    int       progLen;
    memAddr_t expAddr [32];
    word_t    expData [32];
    int       expCount;
    int       errorCount;
    int       checkCount;

    rvPipeline rvPipeline_i (
        .clk, .rst_n, .icacheAddr, .icacheRdata, .dcacheRen, .dcacheWen,
        .dcacheAddr, .dcacheWdata, .dcacheRdata
    );

    memModel memModel_i (
        .clk, .icacheAddr, .icacheRdata, .dcacheRen, .dcacheWen,
        .dcacheAddr, .dcacheWdata, .dcacheRdata
    );

    always #4 clk = ~clk;

    function automatic word_t rType(input logic alt, input regIdx_t rs2, input regIdx_t rs1,
                                    input logic [2:0] f3, input regIdx_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic word_t iType(input logic [11:0] imm, input regIdx_t rs1,
                                    input logic [2:0] f3, input regIdx_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t sType(input logic [11:0] imm, input regIdx_t rs2, input regIdx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    // ne selects bne
    function automatic word_t bType(input logic [12:0] off, input regIdx_t rs2, input regIdx_t rs1,
                                    input logic ne);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t jType(input logic [20:0] off, input regIdx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I result for a funct3 and the funct7 bit 5
    function automatic word_t aluRef(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic clearProgram();
        progLen  = 0;
        expCount = 0;
    endtask

    task automatic emit(input word_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic expectStore(input word_t byteAddr, input word_t data);
        expAddr[expCount] = byteAddr[31:2];
        expData[expCount] = data;
        expCount++;
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input memAddr_t got, input memAddr_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // reset, load, wait for the stores, compare the log
    task automatic runProgram(input string name);
        int cycles;
        int seen;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        memModel_i.clearMemory();
        for (int i = 0; i < progLen; i++) begin
            memModel_i.putInstr(i, prog[i]);
        end
        if (dcacheWen !== 1'b0 || dcacheRen !== 1'b0) begin
            errorCount++;
            $display("%s: data port enables are not low during reset", name);
        end
        checkAddr($sformatf("%s icacheAddr", name), icacheAddr, '0);  // first fetch at 0
        @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (memModel_i.logCount < expCount && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (memModel_i.logCount < expCount) begin
            errorCount++;
            $display("%s: timed out with %0d of %0d stores seen", name,
                     memModel_i.logCount, expCount);
        end
        repeat (10) @(negedge clk);  // lets a stray late store show up
        seen = memModel_i.logCount;
        if (seen != expCount) begin
            errorCount++;
            $display("%s: %0d stores logged but %0d expected", name, seen, expCount);
        end
        for (int i = 0; i < expCount && i < seen; i++) begin
            checkAddr($sformatf("%s dcacheAddr[%0d]", name, i), memModel_i.logAddr[i], expAddr[i]);
            checkWord($sformatf("%s dcacheWdata[%0d]", name, i), memModel_i.logData[i], expData[i]);
        end
    endtask

    task automatic aluChain();
        logic [11:0] imm1;
        logic [11:0] imm2;
        logic [11:0] imm;
        logic [11:0] offs;
        logic [2:0]  f3;
        logic        alt;
        regIdx_t     rs1Idx;
        word_t       v2;
        word_t       prev;
        word_t       b;
        word_t       results [17];
        clearProgram();
        imm1 = 12'($urandom);
        imm2 = 12'($urandom);
        v2   = sext12(imm2);
        prev = sext12(imm1);
        emit(iType(imm1, 5'd0, 3'd0, 5'd1, OP_ITYPE));
        emit(iType(imm2, 5'd0, 3'd0, 5'd2, OP_ITYPE));
        for (int k = 0; k < 17; k++) begin
            f3     = CHAIN_F3[3*k +: 3];
            alt    = CHAIN_ALT[k];
            rs1Idx = (k == 0) ? 5'd1 : regIdx_t'(k + 2);  // previous result
            if (k < 9) begin
                emit(rType(alt, 5'd2, rs1Idx, f3, regIdx_t'(k + 3)));
                b = v2;
            end else begin
                imm = 12'($urandom);
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm[11:5] = {1'b0, alt, 5'b0};  // shamt form
                    b = {27'b0, imm[4:0]};
                end else begin
                    b = sext12(imm);
                end
                emit(iType(imm, rs1Idx, f3, regIdx_t'(k + 3), OP_ITYPE));
            end
            prev       = aluRef(f3, alt, prev, b);
            results[k] = prev;
        end
        for (int k = 0; k < 17; k++) begin
            offs = 12'(12'h100 + 4 * k);
            emit(sType(offs, regIdx_t'(k + 3), 5'd0));
            expectStore({20'b0, offs}, results[k]);
        end
        runProgram("alu chain");
    endtask

    task automatic loadUse();
        logic [11:0] i1;
        logic [11:0] i2;
        clearProgram();
        i1 = 12'($urandom);
        i2 = 12'($urandom);
        emit(iType(i1, 5'd0, 3'd0, 5'd1, OP_ITYPE));
        emit(iType(i2, 5'd0, 3'd0, 5'd2, OP_ITYPE));
        emit(sType(12'h080, 5'd1, 5'd0));
        emit(iType(12'h080, 5'd0, 3'b010, 5'd3, OP_LOAD));
        emit(rType(1'b0, 5'd2, 5'd3, 3'd0, 5'd4));  // uses the load at once
        emit(sType(12'h084, 5'd4, 5'd0));
        expectStore(32'h80, sext12(i1));
        expectStore(32'h84, sext12(i1) + sext12(i2));
        runProgram("load use");
    endtask

    task automatic branchPaths();
        clearProgram();
        emit(iType(12'd7, 5'd0, 3'd0, 5'd3, OP_ITYPE));
        emit(iType(12'd5, 5'd0, 3'd0, 5'd1, OP_ITYPE));
        emit(iType(12'd5, 5'd0, 3'd0, 5'd2, OP_ITYPE));
        emit(bType(13'd8, 5'd2, 5'd1, 1'b0));  // beq taken, x2 still in execute
        emit(sType(12'h090, 5'd3, 5'd0));      // must be skipped
        emit(bType(13'd8, 5'd2, 5'd1, 1'b1));  // bne not taken
        emit(sType(12'h094, 5'd1, 5'd0));
        emit(bType(13'd8, 5'd3, 5'd1, 1'b0));  // beq not taken
        emit(sType(12'h098, 5'd3, 5'd0));
        emit(iType(12'h098, 5'd0, 3'b010, 5'd4, OP_LOAD));
        emit(bType(13'd8, 5'd1, 5'd4, 1'b1));  // bne on a fresh load, taken
        emit(sType(12'h0a0, 5'd1, 5'd0));      // must be skipped
        emit(sType(12'h0a4, 5'd4, 5'd0));
        emit(iType(12'h094, 5'd0, 3'b010, 5'd5, OP_LOAD));
        emit(bType(13'd8, 5'd3, 5'd5, 1'b0));  // beq on a fresh load, not taken
        emit(sType(12'h0a8, 5'd5, 5'd0));
        expectStore(32'h94, 32'd5);
        expectStore(32'h98, 32'd7);
        expectStore(32'ha4, 32'd7);
        expectStore(32'ha8, 32'd5);
        runProgram("branches");
    endtask

    task automatic jalLink();
        word_t jalPc;
        clearProgram();
        emit(iType(12'd3, 5'd0, 3'd0, 5'd1, OP_ITYPE));
        jalPc = progLen * 4;
        emit(jType(21'd8, 5'd5));
        emit(sType(12'h0b0, 5'd1, 5'd0));            // skipped by the jump
        emit(rType(1'b0, 5'd1, 5'd5, 3'd0, 5'd6));  // link used right away
        emit(sType(12'h0b4, 5'd5, 5'd0));
        emit(sType(12'h0b8, 5'd6, 5'd0));
        expectStore(32'hb4, jalPc + 4);
        expectStore(32'hb8, jalPc + 4 + 3);
        runProgram("jal");
    endtask

    task automatic zeroRegister();
        logic [11:0] imm;
        clearProgram();
        imm    = 12'($urandom);
        imm[0] = 1'b1;  // never zero
        emit(iType(imm, 5'd0, 3'd0, 5'd0, OP_ITYPE));
        emit(sType(12'h0c0, 5'd0, 5'd0));
        emit(iType(12'h010, 5'd0, 3'b010, 5'd0, OP_LOAD));  // nonzero fill word into x0
        emit(rType(1'b0, 5'd0, 5'd0, 3'd0, 5'd7));
        emit(sType(12'h0c4, 5'd7, 5'd0));
        emit(sType(12'h0c8, 5'd0, 5'd0));
        expectStore(32'hc0, 32'd0);
        expectStore(32'hc4, 32'd0);
        expectStore(32'hc8, 32'd0);
        runProgram("zero register");
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        errorCount = 0;
        checkCount = 0;
        void'($urandom(22645));
        aluChain();
        loadUse();
        branchPaths();
        jalLink();
        zeroRegister();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
src/rvPkg.sv
src/hazardCtrl.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/rvPipeline.sv
tests/memModel.sv
tests/tbRvPipeline.sv
